// ==== common/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////
    localparam int xlen_c           = 32;
    localparam int imem_words_c     = 256;
    localparam int imem_addr_bits_c = 8;

    ////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////
    // RV32I major opcodes, only the supported subset
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b
    } alu_op_e;

    // Writeback source
    typedef enum logic [1:0] {
        wb_alu,
        wb_mem,
        wb_pc4,
        wb_pcimm
    } wb_sel_e;

    typedef enum logic [1:0] {
        bus_idle,
        bus_req,
        bus_release
    } bus_state_e;

    ////////////////////////////////////////
    // Structs
    ////////////////////////////////////////
    typedef struct packed {
        alu_op_e alu_op;
        logic    src_a_pc;
        logic    src_a_zero;
        logic    src_b_imm;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    is_branch;
        logic    branch_ne;
        logic    is_jal;
        logic    is_jalr;
        wb_sel_e wb_sel;
    } ctrl_t;

    typedef struct packed {
        logic              write;
        logic [xlen_c-1:0] addr;
        logic [xlen_c-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic [xlen_c-1:0] pc;
        logic [31:0]       instr;
        logic [4:0]        rd;
        logic              rd_we;
        logic [xlen_c-1:0] rd_data;
    } retire_t;

    // Nothing written, nothing accessed
    localparam ctrl_t ctrl_nop_c = '{
        alu_op: alu_add,
        wb_sel: wb_alu,
        default: 1'b0
    };

endpackage

`default_nettype wire

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file import cpu_pkg::*; (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic [4:0]         raddr_a,
    input  wire logic [4:0]         raddr_b,
    input  wire logic [4:0]         waddr,
    input  wire logic               we,
    input  wire logic [xlen_c-1:0]  wdata,
    output logic [xlen_c-1:0]       rdata_a,
    output logic [xlen_c-1:0]       rdata_b
);

    logic [xlen_c-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 never written, so it stays zero after reset
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

endmodule

`default_nettype wire

// ==== logic/instr_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_mem import cpu_pkg::*; (
    input  wire logic                        clk,
    input  wire logic                        prog_we,
    input  wire logic [imem_addr_bits_c-1:0] prog_addr,
    input  wire logic [31:0]                 prog_data,
    input  wire logic [xlen_c-1:0]           pc,
    output logic [31:0]                      instr
);

    logic [31:0] mem [imem_words_c];

    // Program load port
    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    // Word index from the byte pc
    assign instr = mem[pc[imem_addr_bits_c+1:2]];

endmodule

`default_nettype wire

// ==== logic/data_bus_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_bus_port import cpu_pkg::*; (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               start_read,
    input  wire logic               start_write,
    input  wire logic [xlen_c-1:0]  addr,
    input  wire logic [xlen_c-1:0]  wdata,
    output logic                    stall,
    output logic [xlen_c-1:0]       load_data,
    output mem_req_t                mem_req,
    output logic                    req,
    input  wire logic               ack,
    input  wire logic [xlen_c-1:0]  rdata
);

    bus_state_e state;
    logic       start;

    assign start = start_read || start_write;

    ////////////////////////////////////////
    // Four-phase handshake FSM
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= bus_idle;
        end else begin
            case (state)
                bus_idle:    if (start) state <= bus_req;
                bus_req:     if (ack) state <= bus_release;
                bus_release: if (!ack) state <= bus_idle;
                default:     state <= bus_idle;
            endcase
        end
    end

    // Request held steady for the whole access
    always_ff @(posedge clk) begin
        if (state == bus_idle && start) begin
            mem_req.write <= start_write;
            mem_req.addr  <= addr;
            mem_req.wdata <= wdata;
        end
        if (state == bus_req && ack) begin
            load_data <= rdata;
        end
    end

    assign req = (state == bus_req);

    // Released once ack is seen low in bus_release
    always_comb begin
        case (state)
            bus_idle:    stall = start;
            bus_req:     stall = 1'b1;
            bus_release: stall = ack;
            default:     stall = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/result_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_select import cpu_pkg::*; (
    input  ctrl_t                   ctrl,
    input  wire logic [xlen_c-1:0]  alu_result,
    input  wire logic [xlen_c-1:0]  load_data,
    input  wire logic [xlen_c-1:0]  pc4,
    input  wire logic [xlen_c-1:0]  pcimm,
    input  wire logic               take_branch,
    output logic [xlen_c-1:0]       rd_data,
    output logic [xlen_c-1:0]       pc_next
);

    // Writeback mux
    always_comb begin
        case (ctrl.wb_sel)
            wb_alu:   rd_data = alu_result;
            wb_mem:   rd_data = load_data;
            wb_pc4:   rd_data = pc4;
            wb_pcimm: rd_data = pcimm;
            default:  rd_data = alu_result;
        endcase
    end

    // Next pc
    always_comb begin
        if (ctrl.is_jalr) begin
            pc_next = {alu_result[xlen_c-1:1], 1'b0};
        end else if (ctrl.is_jal || take_branch) begin
            pc_next = pcimm;
        end else begin
            pc_next = pc4;
        end
    end

endmodule

`default_nettype wire

// ==== decode/instr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decoder import cpu_pkg::*; (
    input  wire logic [31:0] instr,
    output ctrl_t            ctrl,
    output logic [31:0]      imm,
    output logic [4:0]       rs1,
    output logic [4:0]       rs2,
    output logic [4:0]       rd
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    ////////////////////////////////////////
    // Immediate generation
    ////////////////////////////////////////
    always_comb begin
        case (opcode)
            op_store:
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            op_branch:
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            op_lui, op_auipc:
                imm = {instr[31:12], 12'b0};
            op_jal:
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            // I type for jalr, loads and immediate ALU ops
            default:
                imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    ////////////////////////////////////////
    // Control
    ////////////////////////////////////////
    always_comb begin
        ctrl = ctrl_nop_c;
        case (opcode)
            op_lui: begin
                ctrl.src_a_zero = 1'b1;
                ctrl.src_b_imm  = 1'b1;
                ctrl.reg_write  = 1'b1;
            end
            op_auipc: begin
                ctrl.src_a_pc  = 1'b1;
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            op_jal: begin
                ctrl.is_jal    = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = wb_pc4;
            end
            op_jalr: begin
                ctrl.is_jalr   = 1'b1;
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = wb_pc4;
            end
            op_branch: begin
                // beq and bne only, the rest stay a nop
                if (funct3[2:1] == 2'b00) begin
                    ctrl.is_branch = 1'b1;
                    ctrl.branch_ne = funct3[0];
                    ctrl.alu_op    = alu_sub;
                end
            end
            op_load: begin
                if (funct3 == 3'b010) begin
                    ctrl.src_b_imm = 1'b1;
                    ctrl.mem_read  = 1'b1;
                    ctrl.reg_write = 1'b1;
                    ctrl.wb_sel    = wb_mem;
                end
            end
            op_store: begin
                if (funct3 == 3'b010) begin
                    ctrl.src_b_imm = 1'b1;
                    ctrl.mem_write = 1'b1;
                end
            end
            op_imm, op_reg: begin
                ctrl.src_b_imm = (opcode == op_imm);
                ctrl.reg_write = 1'b1;
                case (funct3)
                    3'b000:  ctrl.alu_op = (opcode == op_reg && funct7[5]) ? alu_sub : alu_add;
                    3'b010:  ctrl.alu_op = alu_slt;
                    3'b100:  ctrl.alu_op = alu_xor;
                    3'b110:  ctrl.alu_op = alu_or;
                    3'b111:  ctrl.alu_op = alu_and;
                    // Shifts and sltu not supported
                    default: ctrl = ctrl_nop_c;
                endcase
            end
            default: ctrl = ctrl_nop_c;
        endcase
    end

endmodule

`default_nettype wire

// ==== execute/execute_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_unit import cpu_pkg::*; (
    input  ctrl_t                   ctrl,
    input  wire logic [xlen_c-1:0]  pc,
    input  wire logic [xlen_c-1:0]  rs1_data,
    input  wire logic [xlen_c-1:0]  rs2_data,
    input  wire logic [xlen_c-1:0]  imm,
    output logic [xlen_c-1:0]       alu_result,
    output logic [xlen_c-1:0]       pc4,
    output logic [xlen_c-1:0]       pcimm,
    output logic                    take_branch
);

    logic [xlen_c-1:0] op_a;
    logic [xlen_c-1:0] op_b;
    logic              regs_equal;

    // Operand muxes
    always_comb begin
        if (ctrl.src_a_pc) begin
            op_a = pc;
        end else if (ctrl.src_a_zero) begin
            op_a = '0;
        end else begin
            op_a = rs1_data;
        end
        op_b = ctrl.src_b_imm ? imm : rs2_data;
    end

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////
    always_comb begin
        case (ctrl.alu_op)
            alu_add:    alu_result = op_a + op_b;
            alu_sub:    alu_result = op_a - op_b;
            alu_and:    alu_result = op_a & op_b;
            alu_or:     alu_result = op_a | op_b;
            alu_xor:    alu_result = op_a ^ op_b;
            alu_slt:    alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_pass_b: alu_result = op_b;
            default:    alu_result = '0;
        endcase
    end

    // Branch decision, bne inverts the equality
    assign regs_equal  = (rs1_data == rs2_data);
    assign take_branch = ctrl.is_branch && (regs_equal ^ ctrl.branch_ne);

    // Targets
    assign pc4   = pc + 32'd4;
    assign pcimm = pc + imm;

endmodule

`default_nettype wire

// ==== cpu_core/cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu import cpu_pkg::*; (
    input  wire logic                        clk,
    input  wire logic                        reset,
    input  wire logic                        prog_we,
    input  wire logic [imem_addr_bits_c-1:0] prog_addr,
    input  wire logic [31:0]                 prog_data,
    output logic                             req,
    output mem_req_t                         mem_req,
    input  wire logic                        ack,
    input  wire logic [xlen_c-1:0]           rdata,
    output logic                             retire_valid,
    output retire_t                          retire
);

    logic [xlen_c-1:0] pc;
    logic [xlen_c-1:0] pc_next;
    logic [31:0]       instr;
    ctrl_t             ctrl;
    logic [xlen_c-1:0] imm;
    logic [4:0]        rs1;
    logic [4:0]        rs2;
    logic [4:0]        rd;
    logic [xlen_c-1:0] rs1_data;
    logic [xlen_c-1:0] rs2_data;
    logic [xlen_c-1:0] alu_result;
    logic [xlen_c-1:0] pc4;
    logic [xlen_c-1:0] pcimm;
    logic              take_branch;
    logic [xlen_c-1:0] load_data;
    logic [xlen_c-1:0] rd_data;
    logic              stall;
    logic              run;
    logic              advance;

    ////////////////////////////////////////
    // PC and run control
    ////////////////////////////////////////
    // Core starts fetching one cycle after reset falls
    always_ff @(posedge clk) begin
        if (reset) begin
            run <= 1'b0;
        end else begin
            run <= 1'b1;
        end
    end

    assign advance = run && !stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (advance) begin
            pc <= pc_next;
        end
    end

    ////////////////////////////////////////
    // Stages
    ////////////////////////////////////////
    instr_mem u_instr_mem (
        .clk       (clk),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .pc        (pc),
        .instr     (instr)
    );

    instr_decoder u_instr_decoder (
        .instr (instr),
        .ctrl  (ctrl),
        .imm   (imm),
        .rs1   (rs1),
        .rs2   (rs2),
        .rd    (rd)
    );

    // Register write lands only on the retire cycle
    reg_file u_reg_file (
        .clk     (clk),
        .reset   (reset),
        .raddr_a (rs1),
        .raddr_b (rs2),
        .waddr   (rd),
        .we      (advance && ctrl.reg_write),
        .wdata   (rd_data),
        .rdata_a (rs1_data),
        .rdata_b (rs2_data)
    );

    execute_unit u_execute_unit (
        .ctrl        (ctrl),
        .pc          (pc),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .imm         (imm),
        .alu_result  (alu_result),
        .pc4         (pc4),
        .pcimm       (pcimm),
        .take_branch (take_branch)
    );

    data_bus_port u_data_bus_port (
        .clk         (clk),
        .reset       (reset),
        .start_read  (run && ctrl.mem_read),
        .start_write (run && ctrl.mem_write),
        .addr        (alu_result),
        .wdata       (rs2_data),
        .stall       (stall),
        .load_data   (load_data),
        .mem_req     (mem_req),
        .req         (req),
        .ack         (ack),
        .rdata       (rdata)
    );

    result_select u_result_select (
        .ctrl        (ctrl),
        .alu_result  (alu_result),
        .load_data   (load_data),
        .pc4         (pc4),
        .pcimm       (pcimm),
        .take_branch (take_branch),
        .rd_data     (rd_data),
        .pc_next     (pc_next)
    );

    // Retire record, x0 targets report no write
    assign retire_valid  = advance;
    assign retire.pc     = pc;
    assign retire.instr  = instr;
    assign retire.rd     = rd;
    assign retire.rd_we  = ctrl.reg_write && (rd != 5'd0);
    assign retire.rd_data = retire.rd_we ? rd_data : '0;

endmodule

`default_nettype wire

// ==== test/cpu_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_properties import cpu_pkg::*; (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              req,
    input  wire logic              ack,
    input  wire mem_req_t          mem_req,
    input  wire logic              retire_valid,
    input  wire logic [4:0]        rs1,
    input  wire logic [4:0]        rs2,
    input  wire logic [xlen_c-1:0] rs1_data,
    input  wire logic [xlen_c-1:0] rs2_data
);

    int failures = 0;

    ////////////////////////////////////////
    // Data bus handshake
    ////////////////////////////////////////
    req_held_until_ack: assert property (
        @(posedge clk) disable iff (reset) (req && !ack) |=> req
    ) else begin
        $error("req dropped before ack was seen");
        failures++;
    end

    // Request fields frozen while the access is open
    mem_req_stable: assert property (
        @(posedge clk) disable iff (reset) (req || ack) |=> (!(req || ack) || $stable(mem_req))
    ) else begin
        $error("mem_req changed during an open access");
        failures++;
    end

    ////////////////////////////////////////
    // Core
    ////////////////////////////////////////
    // An open bus access keeps the core stalled
    no_retire_in_stall: assert property (
        @(posedge clk) disable iff (reset) (req || ack) |-> !retire_valid
    ) else begin
        $error("retire_valid high while the core is stalled");
        failures++;
    end

    x0_reads_zero: assert property (
        @(posedge clk) disable iff (reset)
            ((rs1 == 5'd0) |-> (rs1_data == '0)) and ((rs2 == 5'd0) |-> (rs2_data == '0))
    ) else begin
        $error("x0 read back a nonzero value");
        failures++;
    end

endmodule

`default_nettype wire

// ==== test/tb_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu import cpu_pkg::*; ();

    // One program slot and its expected retire values
    typedef struct packed {
        logic [31:0]       instr;
        logic              retires;
        logic [4:0]        rd;
        logic              rd_we;
        logic [xlen_c-1:0] rd_data;
    } step_t;

    logic                        clk = 1'b0;
    logic                        reset;
    logic                        prog_we;
    logic [imem_addr_bits_c-1:0] prog_addr;
    logic [31:0]                 prog_data;
    logic                        req;
    mem_req_t                    mem_req;
    logic                        ack;
    logic [xlen_c-1:0]           rdata;
    logic                        retire_valid;
    retire_t                     retire;

    step_t             program_table[$];
    mem_req_t          store_table[$];
    logic [xlen_c-1:0] data_mem [logic [31:0]];
    int                stores_seen = 0;
    integer            seed = 32'h322;

    always #2 clk = ~clk;

    cpu u_cpu (
        .clk          (clk),
        .reset        (reset),
        .prog_we      (prog_we),
        .prog_addr    (prog_addr),
        .prog_data    (prog_data),
        .req          (req),
        .mem_req      (mem_req),
        .ack          (ack),
        .rdata        (rdata),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    bind cpu cpu_properties u_cpu_properties (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .ack          (ack),
        .mem_req      (mem_req),
        .retire_valid (retire_valid),
        .rs1          (rs1),
        .rs2          (rs2),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data)
    );

    ////////////////////////////////////////
    // RV32I instruction formats
    ////////////////////////////////////////
    function automatic logic [31:0] u_format(opcode_e opcode, logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, opcode};
    endfunction

    function automatic logic [31:0] i_format(opcode_e opcode, logic [2:0] funct3,
                                             logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    function automatic logic [31:0] r_format(logic [6:0] funct7, logic [2:0] funct3,
                                             logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
        return {funct7, rs2, rs1, funct3, rd, op_reg};
    endfunction

    // Word store only
    function automatic logic [31:0] s_format(logic [4:0] rs1, logic [4:0] rs2, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] b_format(logic [2:0] funct3, logic [4:0] rs1,
                                             logic [4:0] rs2, logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic logic [31:0] j_format(logic [4:0] rd, logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (data_mem.exists(addr)) begin
            return data_mem[addr];
        end else begin
            return addr ^ 32'h5a5a_5a5a;
        end
    endfunction

    task automatic add_step(input logic [31:0] instr, input logic [4:0] rd, input logic rd_we,
                            input logic [31:0] rd_data);
        program_table.push_back(step_t'{instr: instr, retires: 1'b1, rd: rd, rd_we: rd_we,
                                        rd_data: rd_data});
    endtask

    // Slot that is jumped over and never retires
    task automatic add_skipped(input logic [31:0] instr);
        program_table.push_back(step_t'{instr: instr, retires: 1'b0, rd: 5'd0, rd_we: 1'b0,
                                        rd_data: '0});
    endtask

    task automatic build_program();
        // Upper immediates
        add_step(u_format(op_lui, 5'd1, 20'h12345), 5'd1, 1'b1, 32'h1234_5000);
        add_step(u_format(op_auipc, 5'd2, 20'h00001), 5'd2, 1'b1, 32'h0000_1004);
        // ALU ops on x3 = 100 and x4 = -7
        add_step(i_format(op_imm, 3'b000, 5'd3, 5'd0, 12'd100), 5'd3, 1'b1, 32'd100);
        add_step(i_format(op_imm, 3'b000, 5'd4, 5'd0, 12'hff9), 5'd4, 1'b1, 32'hffff_fff9);
        add_step(r_format(7'h00, 3'b000, 5'd5, 5'd3, 5'd4), 5'd5, 1'b1, 32'd93);
        add_step(r_format(7'h20, 3'b000, 5'd6, 5'd3, 5'd4), 5'd6, 1'b1, 32'd107);
        add_step(r_format(7'h00, 3'b111, 5'd7, 5'd3, 5'd4), 5'd7, 1'b1, 32'h0000_0060);
        add_step(r_format(7'h00, 3'b110, 5'd8, 5'd3, 5'd4), 5'd8, 1'b1, 32'hffff_fffd);
        add_step(r_format(7'h00, 3'b100, 5'd9, 5'd3, 5'd4), 5'd9, 1'b1, 32'hffff_ff9d);
        add_step(r_format(7'h00, 3'b010, 5'd10, 5'd4, 5'd3), 5'd10, 1'b1, 32'd1);
        add_step(r_format(7'h00, 3'b010, 5'd11, 5'd3, 5'd4), 5'd11, 1'b1, 32'd0);
        // Write to x0 and read it back through an add
        add_step(i_format(op_imm, 3'b000, 5'd0, 5'd3, 12'd5), 5'd0, 1'b0, 32'd0);
        add_step(r_format(7'h00, 3'b000, 5'd12, 5'd0, 5'd3), 5'd12, 1'b1, 32'd100);
        // Taken and not taken beq and bne
        add_step(b_format(3'b000, 5'd3, 5'd4, 13'd8), 5'd0, 1'b0, 32'd0);
        add_step(b_format(3'b001, 5'd3, 5'd4, 13'd8), 5'd0, 1'b0, 32'd0);
        add_skipped(i_format(op_imm, 3'b000, 5'd13, 5'd0, 12'd1));
        add_step(b_format(3'b000, 5'd5, 5'd5, 13'd8), 5'd0, 1'b0, 32'd0);
        add_skipped(i_format(op_imm, 3'b000, 5'd13, 5'd0, 12'd2));
        add_step(b_format(3'b001, 5'd5, 5'd5, 13'd8), 5'd0, 1'b0, 32'd0);
        // Jumps where the jalr target 97 + 4 with bit 0 cleared lands at 100
        add_step(j_format(5'd14, 21'd12), 5'd14, 1'b1, 32'd80);
        add_skipped(i_format(op_imm, 3'b000, 5'd13, 5'd0, 12'd3));
        add_skipped(i_format(op_imm, 3'b000, 5'd13, 5'd0, 12'd4));
        add_step(i_format(op_imm, 3'b000, 5'd15, 5'd0, 12'd97), 5'd15, 1'b1, 32'd97);
        add_step(i_format(op_jalr, 3'b000, 5'd16, 5'd15, 12'd4), 5'd16, 1'b1, 32'd96);
        add_skipped(i_format(op_imm, 3'b000, 5'd13, 5'd0, 12'd5));
        // Stores and loads around 0x100
        add_step(s_format(5'd3, 5'd1, 12'd156), 5'd0, 1'b0, 32'd0);
        add_step(s_format(5'd3, 5'd9, 12'd160), 5'd0, 1'b0, 32'd0);
        add_step(i_format(op_load, 3'b010, 5'd17, 5'd3, 12'd156), 5'd17, 1'b1, 32'h1234_5000);
        add_step(i_format(op_load, 3'b010, 5'd18, 5'd3, 12'd160), 5'd18, 1'b1, 32'hffff_ff9d);
        add_step(r_format(7'h00, 3'b000, 5'd20, 5'd17, 5'd18), 5'd20, 1'b1, 32'h1234_4f9d);
        add_step(s_format(5'd3, 5'd20, 12'd164), 5'd0, 1'b0, 32'd0);
        add_step(i_format(op_load, 3'b010, 5'd21, 5'd3, 12'd164), 5'd21, 1'b1, 32'h1234_4f9d);
        // Branch to itself parks the core
        add_step(b_format(3'b000, 5'd0, 5'd0, 13'd0), 5'd0, 1'b0, 32'd0);

        store_table.push_back(mem_req_t'{write: 1'b1, addr: 32'h100, wdata: 32'h1234_5000});
        store_table.push_back(mem_req_t'{write: 1'b1, addr: 32'h104, wdata: 32'hffff_ff9d});
        store_table.push_back(mem_req_t'{write: 1'b1, addr: 32'h108, wdata: 32'h1234_4f9d});
    endtask

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic compare_retire(input retire_t got, input retire_t exp);
        if (got.pc !== exp.pc || got.instr !== exp.instr || got.rd_we !== exp.rd_we ||
            got.rd_data !== exp.rd_data || (exp.rd_we && got.rd !== exp.rd)) begin
            fail_run($sformatf({"** Error at %0t: retired pc %h instr %h x%0d we %b data %h,",
                                " expected pc %h instr %h x%0d we %b data %h"},
                               $time, got.pc, got.instr, got.rd, got.rd_we, got.rd_data,
                               exp.pc, exp.instr, exp.rd, exp.rd_we, exp.rd_data));
        end
    endtask

    task automatic compare_store(input mem_req_t got, input mem_req_t exp);
        if (got !== exp) begin
            fail_run($sformatf({"** Error at %0t: store write %b addr %h data %h,",
                                " expected write %b addr %h data %h"},
                               $time, got.write, got.addr, got.wdata,
                               exp.write, exp.addr, exp.wdata));
        end
    endtask

    task automatic record_store(input mem_req_t access);
        if (stores_seen >= store_table.size()) begin
            fail_run($sformatf("The core wrote to address %h after the last expected store",
                               access.addr));
        end else begin
            compare_store(access, store_table[stores_seen]);
            stores_seen++;
            data_mem[access.addr] = access.wdata;
        end
    endtask

    task automatic wait_for_retire();
        do begin
            @(negedge clk);
        end while (retire_valid !== 1'b1);
    endtask

    ////////////////////////////////////////
    // Data memory model
    ////////////////////////////////////////
    initial begin : data_memory
        mem_req_t    access;
        int unsigned delay;
        ack   = 1'b0;
        rdata = '0;
        forever begin
            @(negedge clk);
            if (req === 1'b1) begin
                access = mem_req;
                if (access.write) begin
                    record_store(access);
                end
                delay = $random(seed);
                delay = delay % 4;
                repeat (delay) @(posedge clk);
                @(posedge clk);
                #1;
                ack   = 1'b1;
                rdata = access.write ? '0 : read_word(access.addr);
                // Hold ack until the core drops req
                do begin
                    @(negedge clk);
                end while (req === 1'b1);
                @(posedge clk);
                #1;
                ack = 1'b0;
            end
        end
    end

    always @(u_cpu.u_cpu_properties.failures) begin
        if (u_cpu.u_cpu_properties.failures != 0) begin
            fail_run("A bound assertion on the core failed");
        end
    end

    initial begin : watchdog
        @(negedge reset);
        repeat (program_table.size() * 8 + 100) @(posedge clk);
        fail_run("Timeout, the core did not retire the whole program in time");
    end

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial begin : main_sequence
        retire_t expected;
        reset     = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        build_program();
        @(posedge clk);
        #1;
        foreach (program_table[i]) begin
            prog_we   = 1'b1;
            prog_addr = imem_addr_bits_c'(i);
            prog_data = program_table[i].instr;
            @(posedge clk);
            #1;
        end
        prog_we = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        // Retire order follows the table without the skipped slots
        foreach (program_table[i]) begin
            if (program_table[i].retires) begin
                wait_for_retire();
                expected.pc      = xlen_c'(i * 4);
                expected.instr   = program_table[i].instr;
                expected.rd      = program_table[i].rd;
                expected.rd_we   = program_table[i].rd_we;
                expected.rd_data = program_table[i].rd_data;
                compare_retire(retire, expected);
            end
        end

        if (stores_seen != store_table.size()) begin
            fail_run($sformatf("Only %0d of %0d expected stores reached the bus",
                               stores_seen, store_table.size()));
        end else if (u_cpu.u_cpu_properties.failures == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            fail_run("Bound assertions on the core reported failures");
        end
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
common/cpu_pkg.sv
logic/reg_file.sv
logic/instr_mem.sv
logic/data_bus_port.sv
logic/result_select.sv
decode/instr_decoder.sv
execute/execute_unit.sv
cpu_core/cpu.sv
test/cpu_properties.sv
test/tb_cpu.sv
